// File: verilog.f
+incdir+tb
common/ntt_pkg.sv
common/coef_ram_if.sv
design/cbd_sampler.sv
design/coef_ram.sv
ntt/mod_mul.sv
ntt/ntt_butterfly.sv
ntt/ntt_ctrl.sv
design/ntt_server_top.sv
tb/clk_gen.sv
tb/ntt_tb.sv

// File: Makefile
SIM  := obj_dir/Vntt_tb
SRCS := $(wildcard common/*.sv design/*.sv ntt/*.sv tb/*.sv tb/*.svh) verilog.f

.PHONY: all run clean

all: run

$(SIM): $(SRCS)
	verilator --binary --timing --assert -f verilog.f --top-module ntt_tb -Mdir obj_dir

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log

// File: tb/ntt_ref.svh
`ifndef NTT_REF_SVH
`define NTT_REF_SVH

// eta = 2, two plus bits minus two minus bits per nibble
function automatic int cbd_coef(input noise_word_t w, input int s);
	int pos;
	int neg;
	pos = int'(w[4*s]) + int'(w[4*s+1]);
	neg = int'(w[4*s+2]) + int'(w[4*s+3]);
	return (pos - neg + Q) % Q;
endfunction

// in-place Cooley-Tukey, twiddles in bit-reversed order
function automatic void ntt_forward(inout int r [N]);
	int k;
	int t;
	int zeta;
	k = 1;
	for (int len = N/2; len >= 2; len = len / 2) begin
		for (int start = 0; start < N; start += 2*len) begin
			zeta = int'(zeta_at(k));
			k++;
			for (int j = start; j < start + len; j++) begin
				t = (zeta * r[j+len]) % Q;
				r[j+len] = (r[j] - t + Q) % Q;
				r[j] = (r[j] + t) % Q;
			end
		end
	end
endfunction

`endif

// File: tb/ntt_tb.sv
`timescale 1ns/100ps

module ntt_tb;
	import ntt_pkg::*;

	`include "ntt_ref.svh"

	localparam int JOB_TIMEOUT = 20000;	// cycles, stalls included

	logic        clk;
	logic        rst;
	logic        start_i;
	logic        fifo_empty_i = 1'b1;
	noise_word_t din_i = '0;
	logic        fifo_req_o;
	logic        valid_o;
	coef_t       dout_o;
	logic        finish_o;

	int          seed = 96;
	int          val_err = 0;
	int          oth_err = 0;
	bit          started = 1'b0;
	bit          hung = 1'b0;
	bit          stall_mode = 1'b0;
	string       test_name = "idle";
	noise_word_t fifo_q [$];
	logic        req_d;
	int          out_idx;
	int          run_len;	// consecutive valid_o cycles
	coef_t       exp_q [N];
	coef_t       exp_coef;

	clk_gen u_clk (
		.clk_o (clk),
		.rst_o (rst)
	);

	ntt_server_top dut_i (
		.clk          (clk),
		.rst          (rst),
		.start_i      (start_i),
		.fifo_empty_i (fifo_empty_i),
		.din_i        (din_i),
		.fifo_req_o   (fifo_req_o),
		.valid_o      (valid_o),
		.dout_o       (dout_o),
		.finish_o     (finish_o)
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			req_d <= 1'b0;
			out_idx <= 0;
			run_len <= 0;
		end else begin
			req_d <= fifo_req_o;
			if (start_i)
				out_idx <= 0;
			else if (valid_o)
				out_idx <= out_idx + 1;
			run_len <= valid_o ? run_len + 1 : 0;
		end
	end

	assign exp_coef = (out_idx < N) ? exp_q[out_idx[7:0]] : '0;

	// FIFO model, word shows up the cycle after a request
	always @(negedge clk) begin
		int coin;
		coin = 0;
		if (req_d && fifo_q.size() > 0)
			din_i <= fifo_q.pop_front();
		if (stall_mode)
			coin = $random(seed);
		fifo_empty_i <= (fifo_q.size() == 0) || coin[0];
	end

	a_idle_quiet: assert property (@(posedge clk) disable iff (rst)
		!started |-> !fifo_req_o && !valid_o && !finish_o)
		else begin
			oth_err++;
			$display("outputs went active before the first start pulse");
		end

	a_req_not_empty: assert property (@(posedge clk) disable iff (rst)
		fifo_req_o |-> !fifo_empty_i)
		else begin
			oth_err++;
			$display("%s: fifo_req_o raised while the FIFO was empty", test_name);
		end

	a_dout_value: assert property (@(posedge clk) disable iff (rst)
		valid_o |-> dout_o == exp_coef)
		else begin
			val_err++;
			$display("error %s: coef %0d expected %0d actual %0d", test_name,
				$sampled(out_idx), $sampled(exp_coef), $sampled(dout_o));
		end

	a_dout_range: assert property (@(posedge clk) disable iff (rst)
		valid_o |-> dout_o < coef_t'(Q))
		else begin
			val_err++;
			$display("error %s: range expected below %0d actual %0d", test_name,
				Q, $sampled(dout_o));
		end

	a_run_end: assert property (@(posedge clk) disable iff (rst)
		$fell(valid_o) |-> finish_o && run_len == N)
		else begin
			oth_err++;
			$display("%s: output run of %0d cycles not closed by finish_o", test_name,
				$sampled(run_len));
		end

	a_finish_place: assert property (@(posedge clk) disable iff (rst)
		finish_o |-> $fell(valid_o))
		else begin
			oth_err++;
			$display("%s: finish_o pulsed away from the end of the output run", test_name);
		end

	task automatic run_job(input string name, input bit rand_words, input bit stall);
		noise_word_t w;
		int          poly [N];
		int          cyc;
		if (hung)
			return;
		test_name = name;
		for (int i = 0; i < NOISE_WORDS; i++) begin
			w = rand_words ? noise_word_t'($random(seed)) : '0;
			fifo_q.push_back(w);
			for (int s = 0; s < 4; s++)
				poly[4*i + s] = cbd_coef(w, s);
		end
		ntt_forward(poly);
		for (int i = 0; i < N; i++)
			exp_q[i] = coef_t'(poly[i]);
		stall_mode = stall;
		@(negedge clk);
		start_i = 1'b1;
		started = 1'b1;
		@(negedge clk);
		start_i = 1'b0;
		cyc = 0;
		while (!finish_o && cyc < JOB_TIMEOUT) begin
			@(negedge clk);
			cyc++;
		end
		stall_mode = 1'b0;
		if (!finish_o) begin
			hung = 1'b1;
			oth_err++;
			$display("%s: timed out waiting for finish_o", name);
			return;
		end
		a_out_count: assert (out_idx == N)
			else begin
				val_err++;
				$display("error %s: output count expected %0d actual %0d", name, N, out_idx);
			end
	endtask

	initial begin
		int cyc;
		start_i = 1'b0;
		cyc = 0;
		@(negedge clk);
		while (rst === 1'b1 && cyc < 50) begin
			@(negedge clk);
			cyc++;
		end
		if (rst !== 1'b0) begin
			hung = 1'b1;
			oth_err++;
			$display("reset was never released");
		end
		repeat (10) @(negedge clk);	// quiet outputs checked meanwhile
		run_job("zero_noise", 1'b0, 1'b0);
		run_job("random_noise", 1'b1, 1'b0);
		run_job("random_stall", 1'b1, 1'b1);
		run_job("second_random", 1'b1, 1'b0);
		repeat (3) @(negedge clk);
		$display("value errors: %0d, other errors: %0d", val_err, oth_err);
		if (val_err + oth_err == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// File: tb/clk_gen.sv
`timescale 1ns/100ps

module clk_gen (
	output logic clk_o,
	output logic rst_o
);

	initial begin
		clk_o = 1'b0;
		forever #50 clk_o = ~clk_o;	// 100 ns period
	end

	initial begin
		rst_o = 1'b1;
		repeat (8) @(posedge clk_o);
		@(negedge clk_o);
		rst_o = 1'b0;
	end

endmodule

// File: design/ntt_server_top.sv
`timescale 1ns/100ps

module ntt_server_top (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 start_i,
	input  logic                 fifo_empty_i,
	input  ntt_pkg::noise_word_t din_i,
	output logic                 fifo_req_o,
	output logic                 valid_o,
	output ntt_pkg::coef_t       dout_o,
	output logic                 finish_o
);
	import ntt_pkg::*;

	logic  word_valid;
	logic  samp_we;
	coef_t samp_coef;
	logic  samp_busy;
	coef_t zeta;
	logic  bf_valid;

	coef_ram_if ram_if ();

	cbd_sampler u_samp (
		.clk          (clk),
		.rst          (rst),
		.word_valid_i (word_valid),
		.din_i        (din_i),
		.samp_we_o    (samp_we),
		.samp_coef_o  (samp_coef),
		.busy_o       (samp_busy)
	);

	coef_ram u_ram (
		.clk (clk),
		.ram (ram_if.ram)
	);

	ntt_ctrl u_ctrl (
		.clk          (clk),
		.rst          (rst),
		.start_i      (start_i),
		.fifo_empty_i (fifo_empty_i),
		.samp_we_i    (samp_we),
		.samp_coef_i  (samp_coef),
		.samp_busy_i  (samp_busy),
		.fifo_req_o   (fifo_req_o),
		.word_valid_o (word_valid),
		.zeta_o       (zeta),
		.bf_valid_o   (bf_valid),
		.valid_o      (valid_o),
		.dout_o       (dout_o),
		.finish_o     (finish_o),
		.ram          (ram_if.ctrl)
	);

	ntt_butterfly u_bf (
		.clk     (clk),
		.rst     (rst),
		.valid_i (bf_valid),
		.zeta_i  (zeta),
		.ram     (ram_if.bf)
	);

endmodule

// File: ntt/ntt_ctrl.sv
`timescale 1ns/100ps

module ntt_ctrl (
	input  logic           clk,
	input  logic           rst,
	input  logic           start_i,
	input  logic           fifo_empty_i,
	input  logic           samp_we_i,
	input  ntt_pkg::coef_t samp_coef_i,
	input  logic           samp_busy_i,
	output logic           fifo_req_o,
	output logic           word_valid_o,
	output ntt_pkg::coef_t zeta_o,
	output logic           bf_valid_o,
	output logic           valid_o,
	output ntt_pkg::coef_t dout_o,
	output logic           finish_o,
	coef_ram_if.ctrl       ram
);
	import ntt_pkg::*;

	localparam int WR_DLY = RD_LAT + BF_LAT;

	ntt_state_t        state_q;
	addr_t             cnt_q;	// load writes, butterflies, drain, output index
	logic [6:0]        word_cnt_q;
	addr_t             len_q, j_q;
	zeta_idx_t         zidx_q;
	coef_t             zeta_rom [2**$bits(zeta_idx_t)];
	coef_t             zeta_q;
	addr_t             addr_b;
	addr_t             wa_dly [WR_DLY];
	addr_t             wb_dly [WR_DLY];
	logic [RD_LAT-1:0] iss_dly, out_dly;
	logic              grp_end;
	logic              load;

	for (genvar g = 0; g < 2**$bits(zeta_idx_t); g++) begin : g_zeta
		assign zeta_rom[g] = zeta_at(g);
	end

	assign grp_end = (j_q & (len_q - addr_t'(1))) == (len_q - addr_t'(1));
	assign addr_b = j_q + len_q;
	assign load = state_q == LOAD;

	assign fifo_req_o = load && !fifo_empty_i && word_cnt_q != 7'(NOISE_WORDS)
		&& !word_valid_o && !samp_busy_i;

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= IDLE;
			cnt_q <= '0;
			word_cnt_q <= '0;
			len_q <= addr_t'(N/2);
			j_q <= '0;
			zidx_q <= zeta_idx_t'(1);
		end else begin
			case (state_q)
				IDLE: if (start_i) begin
					state_q <= LOAD;
					cnt_q <= '0;
					word_cnt_q <= '0;
				end
				LOAD: begin
					if (fifo_req_o)
						word_cnt_q <= word_cnt_q + 7'd1;
					if (samp_we_i) begin
						cnt_q <= cnt_q + addr_t'(1);
						if (cnt_q == addr_t'(N - 1)) begin
							state_q <= LAYER;
							len_q <= addr_t'(N/2);
							j_q <= '0;
							zidx_q <= zeta_idx_t'(1);
						end
					end
				end
				LAYER: begin
					cnt_q <= cnt_q + addr_t'(1);
					// skip the upper half at the end of a group
					j_q <= grp_end ? j_q + len_q + addr_t'(1) : j_q + addr_t'(1);
					if (grp_end)
						zidx_q <= zidx_q + zeta_idx_t'(1);
					if (cnt_q == addr_t'(N/2 - 1)) begin
						state_q <= DRAIN;
						cnt_q <= '0;
					end
				end
				DRAIN: begin
					cnt_q <= cnt_q + addr_t'(1);
					if (cnt_q == addr_t'(DRAIN_CYCLES - 1)) begin
						cnt_q <= '0;
						j_q <= '0;
						len_q <= len_q >> 1;
						state_q <= (len_q == addr_t'(2)) ? OUTPUT : LAYER;
					end
				end
				OUTPUT: begin
					cnt_q <= cnt_q + addr_t'(1);
					if (cnt_q == addr_t'(N - 1))
						state_q <= DONE;
				end
				DONE: state_q <= IDLE;
				default: state_q <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			word_valid_o <= 1'b0;
			iss_dly <= '0;
			out_dly <= '0;
			finish_o <= 1'b0;
		end else begin
			word_valid_o <= fifo_req_o;	// FIFO answers next cycle
			iss_dly <= (iss_dly << 1) | RD_LAT'(state_q == LAYER);
			out_dly <= (out_dly << 1) | RD_LAT'(state_q == OUTPUT);
			finish_o <= state_q == DONE;
		end
	end

	// twiddle and write addresses follow the RAM read
	always_ff @(posedge clk) begin
		zeta_q <= zeta_rom[zidx_q];
		wa_dly[0] <= j_q;
		wb_dly[0] <= addr_b;
		for (int i = 1; i < WR_DLY; i++) begin
			wa_dly[i] <= wa_dly[i-1];
			wb_dly[i] <= wb_dly[i-1];
		end
	end

	always_comb begin
		ram.rd_addr_a = (state_q == OUTPUT) ? cnt_q : j_q;
		ram.rd_addr_b = addr_b;
		ram.wr_en_a   = load ? samp_we_i : ram.bf_we;
		ram.wr_addr_a = load ? cnt_q : wa_dly[WR_DLY-1];
		ram.wr_data_a = load ? samp_coef_i : ram.bf_res_a;
		ram.wr_en_b   = ram.bf_we;
		ram.wr_addr_b = wb_dly[WR_DLY-1];
		ram.wr_data_b = ram.bf_res_b;
	end

	assign zeta_o = zeta_q;
	assign bf_valid_o = iss_dly[RD_LAT-1];
	assign valid_o = out_dly[RD_LAT-1];
	assign dout_o = ram.rd_data_a;

	// one word in flight at a time, sampler gets its four cycles
	a_fifo_req: assert property (@(posedge clk) disable iff (rst)
		fifo_req_o |-> !fifo_empty_i ##1 !fifo_req_o [*5]);

endmodule

// File: ntt/ntt_butterfly.sv
`timescale 1ns/100ps

module ntt_butterfly (
	input  logic           clk,
	input  logic           rst,
	input  logic           valid_i,
	input  ntt_pkg::coef_t zeta_i,
	coef_ram_if.bf         ram
);
	import ntt_pkg::*;

	coef_t             t;
	coef_t             a_dly [MUL_LAT];
	logic [BF_LAT-1:0] vld_q;
	logic [12:0]       sum, dif;
	coef_t             res_a_q, res_b_q;

	mod_mul u_mul (
		.clk (clk),
		.a_i (ram.rd_data_b),
		.b_i (zeta_i),
		.p_o (t)
	);

	// a waits for t
	always_ff @(posedge clk) begin
		a_dly[0] <= ram.rd_data_a;
		for (int i = 1; i < MUL_LAT; i++)
			a_dly[i] <= a_dly[i-1];
	end

	always_comb begin
		sum = {1'b0, a_dly[MUL_LAT-1]} + {1'b0, t};
		dif = {1'b0, a_dly[MUL_LAT-1]} - {1'b0, t};
	end

	always_ff @(posedge clk) begin
		res_a_q <= (sum >= 13'(Q)) ? 12'(sum - 13'(Q)) : sum[11:0];
		res_b_q <= dif[12] ? 12'(dif[11:0] + 12'(Q)) : dif[11:0];	// on borrow add q back
	end

	always_ff @(posedge clk) begin
		if (rst)
			vld_q <= '0;
		else
			vld_q <= {vld_q[BF_LAT-2:0], valid_i};
	end

	assign ram.bf_we = vld_q[BF_LAT-1];
	assign ram.bf_res_a = res_a_q;
	assign ram.bf_res_b = res_b_q;

	a_bf_result: assert property (@(posedge clk) disable iff (rst)
		ram.bf_we |-> res_a_q < coef_t'(Q) && res_b_q < coef_t'(Q));

endmodule

// File: ntt/mod_mul.sv
`timescale 1ns/100ps

module mod_mul (
	input  logic           clk,
	input  ntt_pkg::coef_t a_i,
	input  ntt_pkg::coef_t b_i,
	output ntt_pkg::coef_t p_o
);
	import ntt_pkg::*;

	prod_t       prod_q;
	prod_t       prod_d;
	logic [11:0] quot_q;
	logic [36:0] est;
	prod_t       rem_w;
	logic [12:0] rem;	// below 2q

	always_comb begin
		est = 37'(prod_q) * 37'(BARRETT_M);
		rem_w = prod_d - prod_t'(quot_q) * prod_t'(Q);
		rem = rem_w[12:0];
	end

	always_ff @(posedge clk) begin
		prod_q <= prod_t'(a_i) * prod_t'(b_i);
		prod_d <= prod_q;
		quot_q <= est[35:24];	// off by at most one
		p_o <= (rem >= 13'(Q)) ? 12'(rem - 13'(Q)) : rem[11:0];
	end

endmodule

// File: design/coef_ram.sv
`timescale 1ns/100ps

module coef_ram (
	input logic   clk,
	coef_ram_if.ram ram
);
	import ntt_pkg::*;

	coef_t mem [N];

	always_ff @(posedge clk) begin
		if (ram.wr_en_a)
			mem[ram.wr_addr_a] <= ram.wr_data_a;
		if (ram.wr_en_b)
			mem[ram.wr_addr_b] <= ram.wr_data_b;
	end

	// registered reads, both ports
	always_ff @(posedge clk) begin
		ram.rd_data_a <= mem[ram.rd_addr_a];
		ram.rd_data_b <= mem[ram.rd_addr_b];
	end

	// load and transform writes must never collide
	a_no_wr_clash: assert property (@(posedge clk)
		!(ram.wr_en_a && ram.wr_en_b && ram.wr_addr_a == ram.wr_addr_b));

endmodule

// File: design/cbd_sampler.sv
`timescale 1ns/100ps

module cbd_sampler (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 word_valid_i,
	input  ntt_pkg::noise_word_t din_i,
	output logic                 samp_we_o,
	output ntt_pkg::coef_t       samp_coef_o,
	output logic                 busy_o
);
	import ntt_pkg::*;

	noise_word_t word_q;
	logic [1:0]  ph_q;	// which nibble
	logic        act_q;
	logic [3:0]  nib;
	logic [1:0]  pos, neg;

	always_ff @(posedge clk) begin
		if (word_valid_i)
			word_q <= din_i;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			act_q <= 1'b0;
			ph_q <= 2'd0;
		end else if (word_valid_i) begin
			act_q <= 1'b1;
			ph_q <= 2'd0;
		end else if (act_q) begin
			ph_q <= ph_q + 2'd1;
			if (ph_q == 2'd3)
				act_q <= 1'b0;
		end
	end

	always_comb begin
		nib = word_q[ph_q*4 +: 4];
		pos = {1'b0, nib[0]} + {1'b0, nib[1]};
		neg = {1'b0, nib[2]} + {1'b0, nib[3]};
		if (pos >= neg)
			samp_coef_o = coef_t'(pos - neg);
		else
			samp_coef_o = coef_t'(Q) - coef_t'(neg - pos);	// -x as q - x
	end

	assign samp_we_o = act_q;
	assign busy_o = act_q;

	// no new word until all four nibbles are out
	a_word_gap: assert property (@(posedge clk) disable iff (rst)
		word_valid_i |-> !act_q);

endmodule

// File: common/coef_ram_if.sv
`timescale 1ns/100ps

interface coef_ram_if;
	import ntt_pkg::*;

	addr_t rd_addr_a, rd_addr_b;
	coef_t rd_data_a, rd_data_b;
	logic  wr_en_a, wr_en_b;
	addr_t wr_addr_a, wr_addr_b;
	coef_t wr_data_a, wr_data_b;

	// butterfly results, put on the write ports by the controller
	logic  bf_we;
	coef_t bf_res_a, bf_res_b;

	modport ram (input rd_addr_a, rd_addr_b, wr_en_a, wr_en_b, wr_addr_a, wr_addr_b,
		wr_data_a, wr_data_b, output rd_data_a, rd_data_b);
	modport ctrl (output rd_addr_a, rd_addr_b, wr_en_a, wr_en_b, wr_addr_a, wr_addr_b,
		wr_data_a, wr_data_b, input rd_data_a, bf_we, bf_res_a, bf_res_b);
	modport bf (input rd_data_a, rd_data_b, output bf_we, bf_res_a, bf_res_b);

endinterface

// File: common/ntt_pkg.sv
package ntt_pkg;

	localparam int Q           = 3329;
	localparam int N           = 256;
	localparam int LOG_N       = 8;
	localparam int NOISE_WORDS = 64;
	localparam int BARRETT_M   = 5039;	// floor(2^24 / q)

	localparam int MUL_LAT      = 3;
	localparam int BF_LAT       = 4;
	localparam int RD_LAT       = 1;
	localparam int DRAIN_CYCLES = RD_LAT + BF_LAT + 1;

	typedef logic [11:0]      coef_t;
	typedef logic [LOG_N-1:0] addr_t;
	typedef logic [6:0]       zeta_idx_t;
	typedef logic [15:0]      noise_word_t;
	typedef logic [23:0]      prod_t;

	typedef enum logic [2:0] {IDLE, LOAD, LAYER, DRAIN, OUTPUT, DONE} ntt_state_t;

	// 17^bitrev7(i) mod q
	function automatic coef_t zeta_at(input int unsigned i);
		int unsigned e;
		int unsigned r;
		int unsigned b;
		e = 0;
		for (int k = 0; k < 7; k++)
			e |= ((i >> k) & 1) << (6 - k);
		r = 1;
		b = 17;
		for (int k = 0; k < 7; k++) begin
			if (e[k])
				r = (r * b) % Q;
			b = (b * b) % Q;
		end
		return coef_t'(r);
	endfunction

endpackage
